// ==== hdl/axi2iob_pkg.sv ====
// AXI to IOb shared types
`default_nettype none

package axi2iob_pkg;

  // AXI burst field widths
  localparam int LEN_W  = 8;
  localparam int SIZE_W = 3;

  // beats in burst minus one
  typedef logic [LEN_W-1:0] axi_len_t;

  // log2 of bytes per beat
  typedef logic [SIZE_W-1:0] axi_size_t;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_DATA = 2'd1,
    ST_RESP = 2'd2
  } burst_state_e;

endpackage

`default_nettype wire

// ==== hdl/axil_if.sv ====
// Internal AXI4-Lite link
`timescale 1ns/1ps
`default_nettype none

interface axil_if #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
);

  localparam int STRB_W = DATA_W / 8;

  // write address and data
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wvalid;
  logic              wready;

  // write response without a resp field
  logic              bvalid;
  logic              bready;

  // read address and data
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [DATA_W-1:0] rdata;
  logic              rvalid;
  logic              rready;

  modport wr_mgr (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  awready, wready, bvalid
  );

  modport rd_mgr (
    output araddr, arvalid, rready,
    input  arready, rdata, rvalid
  );

  modport sub (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    output awready, wready, bvalid, arready, rdata, rvalid
  );

endinterface

`default_nettype wire

// ==== hdl/axi_write_split.sv ====
// AXI4 write burst splitter
`timescale 1ns/1ps
`default_nettype none

module axi_write_split #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32,
  parameter int ID_W   = 8
) (
  input  wire                         clk_i,
  input  wire                         arst_i,
  input  wire  [ID_W-1:0]             s_axi_awid_i,
  input  wire  [ADDR_W-1:0]           s_axi_awaddr_i,
  input  wire  axi2iob_pkg::axi_len_t  s_axi_awlen_i,
  input  wire  axi2iob_pkg::axi_size_t s_axi_awsize_i,
  input  wire                         s_axi_awvalid_i,
  output logic                        s_axi_awready_o,
  input  wire  [DATA_W-1:0]           s_axi_wdata_i,
  input  wire  [DATA_W/8-1:0]         s_axi_wstrb_i,
  input  wire                         s_axi_wvalid_i,
  output logic                        s_axi_wready_o,
  output logic [ID_W-1:0]             s_axi_bid_o,
  output logic                        s_axi_bvalid_o,
  input  wire                         s_axi_bready_i,
  axil_if.wr_mgr                      link
);

  import axi2iob_pkg::*;

  localparam int STRB_W = DATA_W / 8;

  burst_state_e      state_q, state_d;
  logic [ID_W-1:0]   id_q, id_d;
  logic [ADDR_W-1:0] addr_q, addr_d;
  axi_len_t          beats_q, beats_d;
  axi_size_t         size_q, size_d;
  logic              awready_d, wready_d, bvalid_d;
  logic [ID_W-1:0]   bid_d;

  // link side registers
  logic [ADDR_W-1:0] awaddr_q, awaddr_d;
  logic              awvalid_q, awvalid_d;
  logic [DATA_W-1:0] wdata_q, wdata_d;
  logic [STRB_W-1:0] wstrb_q, wstrb_d;
  logic              wvalid_q, wvalid_d;
  logic              bready_q, bready_d;

  assign link.awaddr  = awaddr_q;
  assign link.awvalid = awvalid_q;
  assign link.wdata   = wdata_q;
  assign link.wstrb   = wstrb_q;
  assign link.wvalid  = wvalid_q;
  assign link.bready  = bready_q;

  always_comb begin
    state_d   = state_q;
    id_d      = id_q;
    addr_d    = addr_q;
    beats_d   = beats_q;
    size_d    = size_q;
    awready_d = 1'b0;
    wready_d  = 1'b0;
    bid_d     = s_axi_bid_o;
    bvalid_d  = s_axi_bvalid_o & ~s_axi_bready_i;
    awaddr_d  = awaddr_q;
    awvalid_d = awvalid_q & ~link.awready;
    wdata_d   = wdata_q;
    wstrb_d   = wstrb_q;
    wvalid_d  = wvalid_q & ~link.wready;
    bready_d  = 1'b0;

    case (state_q)
      ST_IDLE: begin
        awready_d = ~awvalid_q;
        if (s_axi_awready_o && s_axi_awvalid_i) begin
          awready_d = 1'b0;
          id_d      = s_axi_awid_i;
          addr_d    = s_axi_awaddr_i;
          beats_d   = s_axi_awlen_i;
          size_d    = s_axi_awsize_i;
          awaddr_d  = s_axi_awaddr_i;
          awvalid_d = 1'b1;
          wready_d  = ~wvalid_q;
          state_d   = ST_DATA;
        end
      end
      ST_DATA: begin
        wready_d = ~wvalid_q;
        if (s_axi_wready_o && s_axi_wvalid_i) begin
          wdata_d  = s_axi_wdata_i;
          wstrb_d  = s_axi_wstrb_i;
          wvalid_d = 1'b1;
          wready_d = 1'b0;
          bready_d = ~s_axi_bvalid_o & ~awvalid_q;
          state_d  = ST_RESP;
        end
      end
      ST_RESP: begin
        bready_d = ~s_axi_bvalid_o & ~awvalid_q;
        if (bready_q && link.bvalid) begin
          bready_d = 1'b0;
          if (beats_q != '0) begin
            // step address by the beat size for the next beat
            beats_d   = beats_q - 1'b1;
            addr_d    = addr_q + (ADDR_W'(1) << size_q);
            awaddr_d  = addr_d;
            awvalid_d = 1'b1;
            wready_d  = ~wvalid_q;
            state_d   = ST_DATA;
          end else begin
            bid_d     = id_q;
            bvalid_d  = 1'b1;
            awready_d = ~awvalid_q;
            state_d   = ST_IDLE;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      state_q         <= ST_IDLE;
      beats_q         <= '0;
      s_axi_awready_o <= 1'b0;
      s_axi_wready_o  <= 1'b0;
      s_axi_bvalid_o  <= 1'b0;
      awvalid_q       <= 1'b0;
      wvalid_q        <= 1'b0;
      bready_q        <= 1'b0;
    end else begin
      state_q         <= state_d;
      beats_q         <= beats_d;
      s_axi_awready_o <= awready_d;
      s_axi_wready_o  <= wready_d;
      s_axi_bvalid_o  <= bvalid_d;
      awvalid_q       <= awvalid_d;
      wvalid_q        <= wvalid_d;
      bready_q        <= bready_d;
    end
  end

  always_ff @(posedge clk_i) begin
    id_q        <= id_d;
    addr_q      <= addr_d;
    size_q      <= size_d;
    s_axi_bid_o <= bid_d;
    awaddr_q    <= awaddr_d;
    wdata_q     <= wdata_d;
    wstrb_q     <= wstrb_d;
  end

endmodule

`default_nettype wire

// ==== hdl/axi_read_split.sv ====
// AXI4 read burst splitter
`timescale 1ns/1ps
`default_nettype none

module axi_read_split #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32,
  parameter int ID_W   = 8
) (
  input  wire                         clk_i,
  input  wire                         arst_i,
  input  wire  [ID_W-1:0]             s_axi_arid_i,
  input  wire  [ADDR_W-1:0]           s_axi_araddr_i,
  input  wire  axi2iob_pkg::axi_len_t  s_axi_arlen_i,
  input  wire  axi2iob_pkg::axi_size_t s_axi_arsize_i,
  input  wire                         s_axi_arvalid_i,
  output logic                        s_axi_arready_o,
  output logic [ID_W-1:0]             s_axi_rid_o,
  output logic [DATA_W-1:0]           s_axi_rdata_o,
  output logic                        s_axi_rlast_o,
  output logic                        s_axi_rvalid_o,
  input  wire                         s_axi_rready_i,
  axil_if.rd_mgr                      link
);

  import axi2iob_pkg::*;

  burst_state_e      state_q, state_d;
  logic [ID_W-1:0]   id_q, id_d;
  logic [ADDR_W-1:0] addr_q, addr_d;
  axi_len_t          beats_q, beats_d;
  axi_size_t         size_q, size_d;
  // a link read is owed for the current beat
  logic              issue_q, issue_d;
  logic              arready_d, rlast_d, rvalid_d;
  logic [ID_W-1:0]   rid_d;
  logic [DATA_W-1:0] rdata_d;
  logic [ADDR_W-1:0] araddr_q, araddr_d;
  logic              arvalid_q, arvalid_d;
  logic              rready_q, rready_d;

  assign link.araddr  = araddr_q;
  assign link.arvalid = arvalid_q;
  assign link.rready  = rready_q;

  always_comb begin
    state_d   = state_q;
    id_d      = id_q;
    addr_d    = addr_q;
    beats_d   = beats_q;
    size_d    = size_q;
    issue_d   = issue_q;
    arready_d = 1'b0;
    rid_d     = s_axi_rid_o;
    rdata_d   = s_axi_rdata_o;
    rlast_d   = s_axi_rlast_o;
    rvalid_d  = s_axi_rvalid_o & ~s_axi_rready_i;
    araddr_d  = araddr_q;
    arvalid_d = arvalid_q & ~link.arready;
    rready_d  = 1'b0;

    case (state_q)
      ST_IDLE: begin
        arready_d = ~arvalid_q;
        if (s_axi_arready_o && s_axi_arvalid_i) begin
          arready_d = 1'b0;
          id_d      = s_axi_arid_i;
          addr_d    = s_axi_araddr_i;
          beats_d   = s_axi_arlen_i;
          size_d    = s_axi_arsize_i;
          issue_d   = 1'b1;
          state_d   = ST_DATA;
        end
      end
      ST_DATA: begin
        rready_d = ~s_axi_rvalid_o & ~arvalid_q & ~issue_q;
        // hold the IOb read back while an R beat still waits
        if (issue_q && (!s_axi_rvalid_o || s_axi_rready_i)) begin
          araddr_d  = addr_q;
          arvalid_d = 1'b1;
          issue_d   = 1'b0;
        end
        if (rready_q && link.rvalid) begin
          rready_d = 1'b0;
          rid_d    = id_q;
          rdata_d  = link.rdata;
          rvalid_d = 1'b1;
          rlast_d  = (beats_q == '0);
          if (beats_q == '0) begin
            arready_d = 1'b1;
            state_d   = ST_IDLE;
          end else begin
            beats_d = beats_q - 1'b1;
            addr_d  = addr_q + (ADDR_W'(1) << size_q);
            issue_d = 1'b1;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      state_q         <= ST_IDLE;
      beats_q         <= '0;
      issue_q         <= 1'b0;
      s_axi_arready_o <= 1'b0;
      s_axi_rlast_o   <= 1'b0;
      s_axi_rvalid_o  <= 1'b0;
      arvalid_q       <= 1'b0;
      rready_q        <= 1'b0;
    end else begin
      state_q         <= state_d;
      beats_q         <= beats_d;
      issue_q         <= issue_d;
      s_axi_arready_o <= arready_d;
      s_axi_rlast_o   <= rlast_d;
      s_axi_rvalid_o  <= rvalid_d;
      arvalid_q       <= arvalid_d;
      rready_q        <= rready_d;
    end
  end

  always_ff @(posedge clk_i) begin
    id_q          <= id_d;
    addr_q        <= addr_d;
    size_q        <= size_d;
    s_axi_rid_o   <= rid_d;
    s_axi_rdata_o <= rdata_d;
    araddr_q      <= araddr_d;
  end

endmodule

`default_nettype wire

// ==== hdl/axil_iob_bridge.sv ====
// AXI4-Lite to IOb bridge
`timescale 1ns/1ps
`default_nettype none

module axil_iob_bridge #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  wire                 clk_i,
  input  wire                 arst_i,
  axil_if.sub                 link,
  output logic                iob_avalid_o,
  output logic [ADDR_W-1:0]   iob_addr_o,
  output logic [DATA_W-1:0]   iob_wdata_o,
  output logic [DATA_W/8-1:0] iob_wstrb_o,
  input  wire                 iob_rvalid_i,
  input  wire  [DATA_W-1:0]   iob_rdata_i,
  input  wire                 iob_ready_i
);

  localparam int STRB_W = DATA_W / 8;

  logic [ADDR_W-1:0] awaddr_q;
  logic              bvalid_q;
  logic              rhold_q;
  logic [DATA_W-1:0] rdata_q;
  logic              wr_en;

  // beats with no strobe set never reach the bus
  assign wr_en = |link.wstrb;

  assign link.awready = iob_ready_i;
  assign link.wready  = iob_ready_i;
  assign link.arready = iob_ready_i;
  assign link.bvalid  = bvalid_q;

  // read result passes straight through, then held until taken
  assign link.rvalid = iob_rvalid_i | rhold_q;
  assign link.rdata  = iob_rvalid_i ? iob_rdata_i : rdata_q;

  assign iob_avalid_o = (link.wvalid & wr_en) | link.arvalid;
  // write address may already be taken before its data arrives
  assign iob_addr_o   = link.arvalid ? link.araddr :
                        (link.awvalid ? link.awaddr : awaddr_q);
  assign iob_wdata_o  = link.wdata;
  assign iob_wstrb_o  = link.arvalid ? {STRB_W{1'b0}} : link.wstrb;

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      bvalid_q <= 1'b0;
      rhold_q  <= 1'b0;
    end else begin
      bvalid_q <= (link.wvalid & iob_ready_i) | (bvalid_q & ~link.bready);
      rhold_q  <= (iob_rvalid_i | rhold_q) & ~link.rready;
    end
  end

  always_ff @(posedge clk_i) begin
    if (link.awvalid) begin
      awaddr_q <= link.awaddr;
    end
    if (iob_rvalid_i) begin
      rdata_q <= iob_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/axi2iob.sv ====
// AXI4 to IOb adapter
`timescale 1ns/1ps
`default_nettype none

module axi2iob #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32,
  parameter int ID_W   = 8
) (
  input  wire                         clk_i,
  input  wire                         arst_i,

  // AXI4 write address
  input  wire  [ID_W-1:0]             s_axi_awid_i,
  input  wire  [ADDR_W-1:0]           s_axi_awaddr_i,
  input  wire  axi2iob_pkg::axi_len_t  s_axi_awlen_i,
  input  wire  axi2iob_pkg::axi_size_t s_axi_awsize_i,
  input  wire                         s_axi_awvalid_i,
  output wire                         s_axi_awready_o,

  // AXI4 write data
  // beat count comes from awlen so wlast is not needed
  input  wire  [DATA_W-1:0]           s_axi_wdata_i,
  input  wire  [DATA_W/8-1:0]         s_axi_wstrb_i,
  input  wire                         s_axi_wlast_i,
  input  wire                         s_axi_wvalid_i,
  output wire                         s_axi_wready_o,

  output wire  [ID_W-1:0]             s_axi_bid_o,
  output wire                         s_axi_bvalid_o,
  input  wire                         s_axi_bready_i,

  // AXI4 read
  input  wire  [ID_W-1:0]             s_axi_arid_i,
  input  wire  [ADDR_W-1:0]           s_axi_araddr_i,
  input  wire  axi2iob_pkg::axi_len_t  s_axi_arlen_i,
  input  wire  axi2iob_pkg::axi_size_t s_axi_arsize_i,
  input  wire                         s_axi_arvalid_i,
  output wire                         s_axi_arready_o,
  output wire  [ID_W-1:0]             s_axi_rid_o,
  output wire  [DATA_W-1:0]           s_axi_rdata_o,
  output wire                         s_axi_rlast_o,
  output wire                         s_axi_rvalid_o,
  input  wire                         s_axi_rready_i,

  // IOb manager
  output wire                         iob_avalid_o,
  output wire  [ADDR_W-1:0]           iob_addr_o,
  output wire  [DATA_W-1:0]           iob_wdata_o,
  output wire  [DATA_W/8-1:0]         iob_wstrb_o,
  input  wire                         iob_rvalid_i,
  input  wire  [DATA_W-1:0]           iob_rdata_i,
  input  wire                         iob_ready_i
);

  axil_if #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) link_if ();

  axi_write_split #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W),
    .ID_W  (ID_W)
  ) u_write_split (
    .clk_i          (clk_i),
    .arst_i         (arst_i),
    .s_axi_awid_i   (s_axi_awid_i),
    .s_axi_awaddr_i (s_axi_awaddr_i),
    .s_axi_awlen_i  (s_axi_awlen_i),
    .s_axi_awsize_i (s_axi_awsize_i),
    .s_axi_awvalid_i(s_axi_awvalid_i),
    .s_axi_awready_o(s_axi_awready_o),
    .s_axi_wdata_i  (s_axi_wdata_i),
    .s_axi_wstrb_i  (s_axi_wstrb_i),
    .s_axi_wvalid_i (s_axi_wvalid_i),
    .s_axi_wready_o (s_axi_wready_o),
    .s_axi_bid_o    (s_axi_bid_o),
    .s_axi_bvalid_o (s_axi_bvalid_o),
    .s_axi_bready_i (s_axi_bready_i),
    .link           (link_if.wr_mgr)
  );

  axi_read_split #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W),
    .ID_W  (ID_W)
  ) u_read_split (
    .clk_i          (clk_i),
    .arst_i         (arst_i),
    .s_axi_arid_i   (s_axi_arid_i),
    .s_axi_araddr_i (s_axi_araddr_i),
    .s_axi_arlen_i  (s_axi_arlen_i),
    .s_axi_arsize_i (s_axi_arsize_i),
    .s_axi_arvalid_i(s_axi_arvalid_i),
    .s_axi_arready_o(s_axi_arready_o),
    .s_axi_rid_o    (s_axi_rid_o),
    .s_axi_rdata_o  (s_axi_rdata_o),
    .s_axi_rlast_o  (s_axi_rlast_o),
    .s_axi_rvalid_o (s_axi_rvalid_o),
    .s_axi_rready_i (s_axi_rready_i),
    .link           (link_if.rd_mgr)
  );

  axil_iob_bridge #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_bridge (
    .clk_i       (clk_i),
    .arst_i      (arst_i),
    .link        (link_if.sub),
    .iob_avalid_o(iob_avalid_o),
    .iob_addr_o  (iob_addr_o),
    .iob_wdata_o (iob_wdata_o),
    .iob_wstrb_o (iob_wstrb_o),
    .iob_rvalid_i(iob_rvalid_i),
    .iob_rdata_i (iob_rdata_i),
    .iob_ready_i (iob_ready_i)
  );

endmodule

`default_nettype wire

// ==== bench/iob_mem_model.sv ====
// IOb memory model
`timescale 1ns/1ps
`default_nettype none

module iob_mem_model #(
  parameter int          ADDR_W = 32,
  parameter int          DATA_W = 32,
  parameter logic [31:0] SEED   = 32'h1
) (
  input  wire                 clk_i,
  input  wire                 arst_i,
  input  wire                 avalid_i,
  input  wire  [ADDR_W-1:0]   addr_i,
  input  wire  [DATA_W-1:0]   wdata_i,
  input  wire  [DATA_W/8-1:0] wstrb_i,
  output logic                rvalid_o,
  output logic [DATA_W-1:0]   rdata_o,
  output logic                ready_o
);

  localparam int STRB_W = DATA_W / 8;

  logic [DATA_W-1:0] mem [0:255];
  logic [31:0]       rand_q;
  logic [7:0]        idx;
  logic              rd_acc;
  logic              wr_acc;

  assign idx    = addr_i[9:2];
  assign rd_acc = avalid_i & ready_o & (wstrb_i == '0);
  assign wr_acc = avalid_i & ready_o & (wstrb_i != '0);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // each word starts with a pattern built from its own index
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = DATA_W'({4{i[7:0]}} ^ 32'hc33c_5aa5);
    end
  end

  // ready drops about one cycle in four
  always @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      rand_q   <= SEED;
      ready_o  <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rand_q   <= xorshift(rand_q);
      ready_o  <= (rand_q[1:0] != 2'b00);
      rvalid_o <= rd_acc;
      if (rd_acc) begin
        rdata_o <= mem[idx];
      end
    end
  end

  always @(posedge clk_i) begin
    if (wr_acc) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/axi2iob_tb.sv ====
// AXI to IOb testbench
`timescale 1ns/1ps
`default_nettype none

module axi2iob_tb;

  import axi2iob_pkg::*;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ID_W   = 8;
  localparam int STRB_W = DATA_W / 8;
  // worst case beats over all tests
  localparam int MAX_BEATS      = 2 + 16 + 8 + 40 * 16;
  localparam int TIMEOUT_CYCLES = MAX_BEATS * 40 + 200;

  logic              clk = 1'b0;
  logic              arst;
  logic [ID_W-1:0]   s_axi_awid;
  logic [ADDR_W-1:0] s_axi_awaddr;
  axi_len_t          s_axi_awlen;
  axi_size_t         s_axi_awsize;
  logic              s_axi_awvalid;
  wire               s_axi_awready;
  logic [DATA_W-1:0] s_axi_wdata;
  logic [STRB_W-1:0] s_axi_wstrb;
  logic              s_axi_wlast;
  logic              s_axi_wvalid;
  wire               s_axi_wready;
  wire  [ID_W-1:0]   s_axi_bid;
  wire               s_axi_bvalid;
  logic              s_axi_bready = 1'b0;
  logic [ID_W-1:0]   s_axi_arid;
  logic [ADDR_W-1:0] s_axi_araddr;
  axi_len_t          s_axi_arlen;
  axi_size_t         s_axi_arsize;
  logic              s_axi_arvalid;
  wire               s_axi_arready;
  wire  [ID_W-1:0]   s_axi_rid;
  wire  [DATA_W-1:0] s_axi_rdata;
  wire               s_axi_rlast;
  wire               s_axi_rvalid;
  logic              s_axi_rready = 1'b0;
  wire               iob_avalid;
  wire  [ADDR_W-1:0] iob_addr;
  wire  [DATA_W-1:0] iob_wdata;
  wire  [STRB_W-1:0] iob_wstrb;
  wire               iob_rvalid;
  wire  [DATA_W-1:0] iob_rdata;
  wire               iob_ready;

  // shadow memory and expected responses
  logic [DATA_W-1:0] shadow [0:255];
  logic [DATA_W-1:0] beat_data [0:15];
  logic [STRB_W-1:0] beat_strb [0:15];
  logic [ID_W-1:0]   exp_bid[$];
  logic [ID_W-1:0]   exp_rid[$];
  logic [DATA_W-1:0] exp_rdata[$];
  logic              exp_rlast[$];

  logic [31:0] rng_state = 32'd87802;
  logic [31:0] bp_state  = 32'd87802 ^ 32'h9e3779b9;
  int          b_issued = 0;
  int          b_seen = 0;
  int          r_issued = 0;
  int          r_seen = 0;
  int          error_count = 0;
  int          err_base = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle_count = 0;
  string       test_name = "none";

  always #50 clk = ~clk;

  axi2iob #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W),
    .ID_W  (ID_W)
  ) dut (
    .clk_i          (clk),
    .arst_i         (arst),
    .s_axi_awid_i   (s_axi_awid),
    .s_axi_awaddr_i (s_axi_awaddr),
    .s_axi_awlen_i  (s_axi_awlen),
    .s_axi_awsize_i (s_axi_awsize),
    .s_axi_awvalid_i(s_axi_awvalid),
    .s_axi_awready_o(s_axi_awready),
    .s_axi_wdata_i  (s_axi_wdata),
    .s_axi_wstrb_i  (s_axi_wstrb),
    .s_axi_wlast_i  (s_axi_wlast),
    .s_axi_wvalid_i (s_axi_wvalid),
    .s_axi_wready_o (s_axi_wready),
    .s_axi_bid_o    (s_axi_bid),
    .s_axi_bvalid_o (s_axi_bvalid),
    .s_axi_bready_i (s_axi_bready),
    .s_axi_arid_i   (s_axi_arid),
    .s_axi_araddr_i (s_axi_araddr),
    .s_axi_arlen_i  (s_axi_arlen),
    .s_axi_arsize_i (s_axi_arsize),
    .s_axi_arvalid_i(s_axi_arvalid),
    .s_axi_arready_o(s_axi_arready),
    .s_axi_rid_o    (s_axi_rid),
    .s_axi_rdata_o  (s_axi_rdata),
    .s_axi_rlast_o  (s_axi_rlast),
    .s_axi_rvalid_o (s_axi_rvalid),
    .s_axi_rready_i (s_axi_rready),
    .iob_avalid_o   (iob_avalid),
    .iob_addr_o     (iob_addr),
    .iob_wdata_o    (iob_wdata),
    .iob_wstrb_o    (iob_wstrb),
    .iob_rvalid_i   (iob_rvalid),
    .iob_rdata_i    (iob_rdata),
    .iob_ready_i    (iob_ready)
  );

  iob_mem_model #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W),
    .SEED  (32'd87802 ^ 32'h2545f491)
  ) u_mem (
    .clk_i   (clk),
    .arst_i  (arst),
    .avalid_i(iob_avalid),
    .addr_i  (iob_addr),
    .wdata_i (iob_wdata),
    .wstrb_i (iob_wstrb),
    .rvalid_o(iob_rvalid),
    .rdata_o (iob_rdata),
    .ready_o (iob_ready)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // reference for a write burst
  // beat i lands at addr + i * 2**size
  function automatic void predict_write(input logic [ID_W-1:0] id,
                                        input logic [ADDR_W-1:0] addr,
                                        input axi_len_t len, input axi_size_t size);
    logic [ADDR_W-1:0] a;
    int                i;
    int                b;
    for (i = 0; i <= int'(len); i++) begin
      a = addr + ADDR_W'(i) * (ADDR_W'(1) << size);
      if (beat_strb[i] != '0) begin
        for (b = 0; b < STRB_W; b++) begin
          if (beat_strb[i][b]) begin
            shadow[a[9:2]][8*b +: 8] = beat_data[i][8*b +: 8];
          end
        end
      end
    end
    exp_bid.push_back(id);
  endfunction

  function automatic void predict_read(input logic [ID_W-1:0] id,
                                       input logic [ADDR_W-1:0] addr,
                                       input axi_len_t len, input axi_size_t size);
    logic [ADDR_W-1:0] a;
    int                i;
    for (i = 0; i <= int'(len); i++) begin
      a = addr + ADDR_W'(i) * (ADDR_W'(1) << size);
      exp_rdata.push_back(shadow[a[9:2]]);
      exp_rid.push_back(id);
      exp_rlast.push_back(i == int'(len));
    end
  endfunction

  task automatic check_data(input string label, input logic [DATA_W-1:0] exp_v,
                            input logic [DATA_W-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("Fail %s %s: expected %h, actual %h", test_name, label, exp_v, act_v);
      error_count++;
    end
  endtask

  task automatic check_id(input string label, input logic [ID_W-1:0] exp_v,
                          input logic [ID_W-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("Fail %s %s: expected %h, actual %h", test_name, label, exp_v, act_v);
      error_count++;
    end
  endtask

  task automatic check_bit(input string label, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("Fail %s %s: expected %b, actual %b", test_name, label, exp_v, act_v);
      error_count++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_base  = error_count;
  endtask

  task automatic finish_test();
    int errs;
    errs = error_count - err_base;
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errs);
    end
  endtask

  task automatic write_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                             input axi_len_t len, input axi_size_t size);
    int i;
    predict_write(id, addr, len, size);
    b_issued++;
    @(posedge clk);
    s_axi_awid    <= id;
    s_axi_awaddr  <= addr;
    s_axi_awlen   <= len;
    s_axi_awsize  <= size;
    s_axi_awvalid <= 1'b1;
    do @(negedge clk); while (!s_axi_awready);
    @(posedge clk);
    s_axi_awvalid <= 1'b0;
    for (i = 0; i <= int'(len); i++) begin
      s_axi_wdata  <= beat_data[i];
      s_axi_wstrb  <= beat_strb[i];
      s_axi_wlast  <= (i == int'(len));
      s_axi_wvalid <= 1'b1;
      do @(negedge clk); while (!s_axi_wready);
      @(posedge clk);
    end
    s_axi_wvalid <= 1'b0;
    s_axi_wlast  <= 1'b0;
    while (b_seen != b_issued) @(posedge clk);
  endtask

  task automatic read_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                            input axi_len_t len, input axi_size_t size);
    predict_read(id, addr, len, size);
    r_issued += int'(len) + 1;
    @(posedge clk);
    s_axi_arid    <= id;
    s_axi_araddr  <= addr;
    s_axi_arlen   <= len;
    s_axi_arsize  <= size;
    s_axi_arvalid <= 1'b1;
    do @(negedge clk); while (!s_axi_arready);
    @(posedge clk);
    s_axi_arvalid <= 1'b0;
    while (r_seen != r_issued) @(posedge clk);
  endtask

  // random B and R back-pressure
  always @(posedge clk) begin
    bp_state = xorshift(bp_state);
    s_axi_bready <= (bp_state[1:0] != 2'b00);
    s_axi_rready <= (bp_state[3:2] != 2'b00);
  end

  // handshakes sampled at the falling edge complete on the next rising edge
  always @(negedge clk) begin : compare_responses
    logic [ID_W-1:0]   id_exp;
    logic [DATA_W-1:0] data_exp;
    logic              last_exp;
    if (s_axi_bvalid && s_axi_bready) begin
      if (exp_bid.size() == 0) begin
        $display("%s: write response arrived with no write burst waiting", test_name);
        error_count++;
      end else begin
        id_exp = exp_bid.pop_front();
        check_id("bid", id_exp, s_axi_bid);
      end
      b_seen++;
    end
    if (s_axi_rvalid && s_axi_rready) begin
      if (exp_rdata.size() == 0) begin
        $display("%s: read beat arrived with no read burst waiting", test_name);
        error_count++;
      end else begin
        data_exp = exp_rdata.pop_front();
        id_exp   = exp_rid.pop_front();
        last_exp = exp_rlast.pop_front();
        check_data("rdata", data_exp, s_axi_rdata);
        check_id("rid", id_exp, s_axi_rid);
        check_bit("rlast", last_exp, s_axi_rlast);
      end
      r_seen++;
    end
  end

  initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: no progress after %0d cycles in test %s", cycle_count, test_name);
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    logic [31:0]       r;
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
    axi_len_t          len;
    axi_size_t         size;
    int                n;
    int                i;
    // same start pattern as the memory model
    for (i = 0; i < 256; i++) begin
      shadow[i] = {4{i[7:0]}} ^ 32'hc33c_5aa5;
    end
    arst          <= 1'b1;
    s_axi_awid    <= '0;
    s_axi_awaddr  <= '0;
    s_axi_awlen   <= '0;
    s_axi_awsize  <= '0;
    s_axi_awvalid <= 1'b0;
    s_axi_wdata   <= '0;
    s_axi_wstrb   <= '0;
    s_axi_wlast   <= 1'b0;
    s_axi_wvalid  <= 1'b0;
    s_axi_arid    <= '0;
    s_axi_araddr  <= '0;
    s_axi_arlen   <= '0;
    s_axi_arsize  <= '0;
    s_axi_arvalid <= 1'b0;

    start_test("reset");
    repeat (16) @(posedge clk);
    arst <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_bit("bvalid", 1'b0, s_axi_bvalid);
    check_bit("rvalid", 1'b0, s_axi_rvalid);
    check_bit("wready", 1'b0, s_axi_wready);
    check_bit("rlast", 1'b0, s_axi_rlast);
    check_bit("iob_avalid", 1'b0, iob_avalid);
    check_bit("awready", 1'b1, s_axi_awready);
    check_bit("arready", 1'b1, s_axi_arready);
    finish_test();

    start_test("single_beat");
    beat_data[0] = 32'h1234_5678;
    beat_strb[0] = 4'hf;
    write_burst(8'h11, 32'h40, 8'd0, 3'd2);
    read_burst(8'h22, 32'h40, 8'd0, 3'd2);
    finish_test();

    start_test("burst8");
    for (i = 0; i < 8; i++) begin
      beat_data[i] = next_rand();
      beat_strb[i] = 4'hf;
    end
    write_burst(8'h35, 32'h100, 8'd7, 3'd2);
    read_burst(8'h36, 32'h100, 8'd7, 3'd2);
    finish_test();

    // second beat has no strobes and must leave its word alone
    start_test("strobes");
    beat_strb[0] = 4'b0011;
    beat_strb[1] = 4'b0000;
    beat_strb[2] = 4'b1000;
    beat_strb[3] = 4'b0101;
    for (i = 0; i < 4; i++) begin
      beat_data[i] = next_rand();
    end
    write_burst(8'h47, 32'h100, 8'd3, 3'd2);
    read_burst(8'h48, 32'h100, 8'd3, 3'd2);
    finish_test();

    start_test("random");
    for (n = 0; n < 40; n++) begin
      r    = next_rand();
      len  = axi_len_t'(r[3:0]);
      size = axi_size_t'(r[5:4] % 3);
      id   = r[31:24];
      addr = {22'd0, r[17:8]};
      addr = addr & ~((ADDR_W'(1) << size) - ADDR_W'(1));
      if (r[6]) begin
        for (i = 0; i <= int'(len); i++) begin
          r            = next_rand();
          beat_strb[i] = r[3:0];
          beat_data[i] = next_rand();
        end
        write_burst(id, addr, len, size);
      end else begin
        read_burst(id, addr, len, size);
      end
    end
    finish_test();

    repeat (4) @(posedge clk);
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/axi2iob_pkg.sv
hdl/axil_if.sv
hdl/axi_write_split.sv
hdl/axi_read_split.sv
hdl/axil_iob_bridge.sv
hdl/axi2iob.sv
bench/iob_mem_model.sv
bench/axi2iob_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the AXI to IOb testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary -Wno-fatal --top-module axi2iob_tb -f list.f -o axi2iob_sim; then
  echo "build failed"
  exit 1
fi

sim_out=$(./obj_dir/axi2iob_sim)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "Simulation completed successfully"; then
  exit 0
fi
exit 1
